//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

   // Host and memory words, byte addresses
   typedef logic [15:0] word_t;
   typedef logic [15:0] addr_t;

   // Address fields: tag [15:11], set index [10:3], word [2:1]
   typedef logic [4:0] tag_t;
   typedef logic [7:0] index_t;
   typedef logic [1:0] word_sel_t;

   typedef logic way_t;

   localparam int NUM_SETS = 256;
   localparam int WORDS_PER_LINE = 4;

   // Cycles from a mem_rd strobe to valid mem_rdata
   localparam int MEM_READ_LATENCY = 2;

   typedef enum logic [2:0] {
      idle,
      lookup,
      compare,
      write_back,
      refill_issue,
      refill_wait,
      write_around,
      finish
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way (
   input  logic                clk,
   input  logic                reset,
   input  cache_pkg::index_t    index,
   input  cache_pkg::word_sel_t word_sel,
   input  logic                word_write,
   input  cache_pkg::word_t     wdata,
   input  logic                line_fill,
   input  cache_pkg::tag_t      fill_tag,
   input  logic                mark_dirty,
   output cache_pkg::word_t     rdata,
   output cache_pkg::tag_t      tag_out,
   output logic                valid,
   output logic                dirty
);

   cache_pkg::word_t data_mem [cache_pkg::NUM_SETS][cache_pkg::WORDS_PER_LINE];
   cache_pkg::tag_t  tag_mem [cache_pkg::NUM_SETS];

   logic [cache_pkg::NUM_SETS-1:0] valid_bits;
   logic [cache_pkg::NUM_SETS-1:0] dirty_bits;

   // Data and tag arrays, read one cycle after the address
   always_ff @(posedge clk) begin
      if (word_write) begin
         data_mem[index][word_sel] <= wdata;
      end
      if (line_fill) begin
         tag_mem[index] <= fill_tag;
      end
      rdata <= data_mem[index][word_sel];
      tag_out <= tag_mem[index];
   end

   // Line state per set
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
         valid <= 1'b0;
         dirty <= 1'b0;
      end else begin
         if (line_fill) begin
            // New line arrives clean
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
         end else if (mark_dirty) begin
            dirty_bits[index] <= 1'b1;
         end
         valid <= valid_bits[index];
         dirty <= dirty_bits[index];
      end
   end

   // A fill and a store hit never target the same way together
   fill_not_dirty: assert property (
      @(posedge clk) disable iff (reset) !(line_fill && mark_dirty)
   );

endmodule

`default_nettype wire

//--- verilog/lru_table.sv
`timescale 1ns/1ps
`default_nettype none

module lru_table (
   input  logic             clk,
   input  logic             reset,
   input  cache_pkg::index_t index,
   input  logic             valid0,
   input  logic             valid1,
   input  logic             touch,
   input  cache_pkg::way_t   touched_way,
   output cache_pkg::way_t   victim_way
);

   // One bit per set, naming the least recently used way
   logic [cache_pkg::NUM_SETS-1:0] lru_bits;
   cache_pkg::way_t lru_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         lru_bits <= '0;
         lru_q <= 1'b0;
      end else begin
         if (touch) begin
            lru_bits[index] <= ~touched_way;
         end
         lru_q <= lru_bits[index];
      end
   end

   // Empty ways are filled first, way 0 before way 1
   always_comb begin
      if (!valid0) begin
         victim_way = 1'b0;
      end else if (!valid1) begin
         victim_way = 1'b1;
      end else begin
         victim_way = lru_q;
      end
   end

endmodule

`default_nettype wire

//--- verilog/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
   input  logic                clk,
   input  logic                reset,
   // Host side
   input  logic                req,
   input  logic                wr,
   input  cache_pkg::addr_t     addr,
   input  cache_pkg::word_t     data_in,
   output logic                done,
   output logic                cache_hit,
   output cache_pkg::word_t     data_out,
   // Memory side
   output logic                mem_rd,
   output logic                mem_wr,
   output cache_pkg::addr_t     mem_addr,
   output cache_pkg::word_t     mem_wdata,
   input  cache_pkg::word_t     mem_rdata,
   // Way controls
   output cache_pkg::index_t    index,
   output cache_pkg::word_sel_t word_sel,
   output logic                way0_write,
   output logic                way1_write,
   output cache_pkg::word_t     way_wdata,
   output logic                way0_fill,
   output logic                way1_fill,
   output cache_pkg::tag_t      fill_tag,
   output logic                way0_mark_dirty,
   output logic                way1_mark_dirty,
   // Way status
   input  cache_pkg::word_t     way0_rdata,
   input  cache_pkg::word_t     way1_rdata,
   input  cache_pkg::tag_t      way0_tag,
   input  cache_pkg::tag_t      way1_tag,
   input  logic                way0_valid,
   input  logic                way1_valid,
   input  logic                way0_dirty,
   input  logic                way1_dirty,
   // LRU
   output logic                touch,
   output cache_pkg::way_t      touched_way,
   input  cache_pkg::way_t      victim_way
);

   cache_pkg::ctrl_state_t state;
   cache_pkg::ctrl_state_t next_state;

   // Latched request
   logic                req_wr;
   cache_pkg::addr_t     req_addr;
   cache_pkg::word_t     req_data;
   cache_pkg::tag_t      req_tag;
   cache_pkg::index_t    req_index;
   cache_pkg::word_sel_t req_word_sel;

   // Miss bookkeeping
   cache_pkg::way_t      victim;
   cache_pkg::tag_t      victim_tag;
   logic [1:0]          cnt;
   cache_pkg::word_sel_t issue_sel;
   cache_pkg::word_t     crit_word;

   // Reads in flight and the word each one returns
   logic [cache_pkg::MEM_READ_LATENCY-1:0] rd_pipe_v;
   cache_pkg::word_sel_t rd_pipe_off [cache_pkg::MEM_READ_LATENCY];
   logic                ret_valid;
   cache_pkg::word_sel_t ret_off;
   logic                last_ret;

   logic                hit0;
   logic                hit1;
   logic                any_hit;
   logic                in_compare;
   logic                victim_dirty;

   assign req_tag = req_addr[15:11];
   assign req_index = req_addr[10:3];
   assign req_word_sel = req_addr[2:1];

   assign hit0 = way0_valid && (way0_tag == req_tag);
   assign hit1 = way1_valid && (way1_tag == req_tag);
   assign any_hit = hit0 || hit1;
   assign in_compare = (state == cache_pkg::compare);
   assign victim_dirty = victim_way ? (way1_valid && way1_dirty) : (way0_valid && way0_dirty);

   // Refill goes critical word first and wraps within the line
   assign issue_sel = req_word_sel + cnt;

   assign ret_valid = rd_pipe_v[cache_pkg::MEM_READ_LATENCY-1];
   assign ret_off = rd_pipe_off[cache_pkg::MEM_READ_LATENCY-1];
   assign last_ret = ret_valid && (ret_off == req_word_sel - 2'd1);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= cache_pkg::idle;
         cnt <= 2'd0;
      end else begin
         state <= next_state;
         if (state == cache_pkg::write_back || state == cache_pkg::refill_issue) begin
            cnt <= cnt + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == cache_pkg::idle && req) begin
         req_wr <= wr;
         req_addr <= addr;
         req_data <= data_in;
      end
      if (in_compare && !any_hit) begin
         victim <= victim_way;
         victim_tag <= victim_way ? way1_tag : way0_tag;
      end
      if (ret_valid && ret_off == req_word_sel) begin
         crit_word <= mem_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_pipe_v <= '0;
      end else begin
         rd_pipe_v[0] <= mem_rd;
         for (int i = 1; i < cache_pkg::MEM_READ_LATENCY; i++) begin
            rd_pipe_v[i] <= rd_pipe_v[i-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      rd_pipe_off[0] <= issue_sel;
      for (int i = 1; i < cache_pkg::MEM_READ_LATENCY; i++) begin
         rd_pipe_off[i] <= rd_pipe_off[i-1];
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         cache_pkg::idle: begin
            if (req) begin
               next_state = cache_pkg::lookup;
            end
         end
         cache_pkg::lookup: begin
            next_state = cache_pkg::compare;
         end
         cache_pkg::compare: begin
            if (any_hit) begin
               next_state = cache_pkg::idle;
            end else if (req_wr) begin
               next_state = cache_pkg::write_around;
            end else if (victim_dirty) begin
               next_state = cache_pkg::write_back;
            end else begin
               next_state = cache_pkg::refill_issue;
            end
         end
         cache_pkg::write_back: begin
            if (cnt == 2'd3) begin
               next_state = cache_pkg::refill_issue;
            end
         end
         cache_pkg::refill_issue: begin
            if (cnt == 2'd3) begin
               next_state = cache_pkg::refill_wait;
            end
         end
         cache_pkg::refill_wait: begin
            if (last_ret) begin
               next_state = cache_pkg::finish;
            end
         end
         cache_pkg::write_around: begin
            next_state = cache_pkg::finish;
         end
         default: begin
            next_state = cache_pkg::idle;
         end
      endcase
   end

   // Host outputs
   assign done = (in_compare && any_hit) || (state == cache_pkg::finish);
   assign cache_hit = in_compare && any_hit;
   assign data_out = in_compare ? (hit1 ? way1_rdata : way0_rdata) : crit_word;

   // Memory outputs
   assign mem_rd = (state == cache_pkg::refill_issue);
   assign mem_wr = (state == cache_pkg::write_back) || (state == cache_pkg::write_around);
   assign mem_wdata = (state == cache_pkg::write_back) ?
                      (victim ? way1_rdata : way0_rdata) : req_data;

   always_comb begin
      case (state)
         cache_pkg::write_back:   mem_addr = {victim_tag, req_index, cnt, 1'b0};
         cache_pkg::write_around: mem_addr = req_addr;
         default:                 mem_addr = {req_tag, req_index, issue_sel, 1'b0};
      endcase
   end

   // Write-back reads the ways one word ahead of the strobe
   assign index = req_index;

   always_comb begin
      if (ret_valid) begin
         word_sel = ret_off;
      end else if (in_compare) begin
         word_sel = req_wr ? req_word_sel : 2'd0;
      end else if (state == cache_pkg::write_back) begin
         word_sel = cnt + 2'd1;
      end else begin
         word_sel = req_word_sel;
      end
   end

   assign way_wdata = in_compare ? req_data : mem_rdata;
   assign way0_write = (in_compare && req_wr && hit0) || (ret_valid && !victim);
   assign way1_write = (in_compare && req_wr && hit1) || (ret_valid && victim);
   assign way0_mark_dirty = in_compare && req_wr && hit0;
   assign way1_mark_dirty = in_compare && req_wr && hit1;
   assign way0_fill = last_ret && !victim;
   assign way1_fill = last_ret && victim;
   assign fill_tag = req_tag;

   // Load hits and completed refills refresh the LRU order
   assign touch = (in_compare && any_hit && !req_wr) || last_ret;
   assign touched_way = in_compare ? hit1 : victim;

   no_req_while_busy: assert property (
      @(posedge clk) disable iff (reset) req |-> state == cache_pkg::idle
   );

   one_way_written: assert property (
      @(posedge clk) disable iff (reset) !(way0_write && way1_write)
   );

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
   input  logic            clk,
   input  logic            reset,
   input  logic            req,
   input  logic            wr,
   input  cache_pkg::addr_t addr,
   input  cache_pkg::word_t data_in,
   output logic            done,
   output logic            cache_hit,
   output cache_pkg::word_t data_out,
   output logic            mem_rd,
   output logic            mem_wr,
   output cache_pkg::addr_t mem_addr,
   output cache_pkg::word_t mem_wdata,
   input  cache_pkg::word_t mem_rdata
);

   cache_pkg::index_t    index;
   cache_pkg::word_sel_t word_sel;
   cache_pkg::word_t     way_wdata;
   cache_pkg::tag_t      fill_tag;
   logic                way0_write;
   logic                way1_write;
   logic                way0_fill;
   logic                way1_fill;
   logic                way0_mark_dirty;
   logic                way1_mark_dirty;
   cache_pkg::word_t     way0_rdata;
   cache_pkg::word_t     way1_rdata;
   cache_pkg::tag_t      way0_tag;
   cache_pkg::tag_t      way1_tag;
   logic                way0_valid;
   logic                way1_valid;
   logic                way0_dirty;
   logic                way1_dirty;
   logic                touch;
   cache_pkg::way_t      touched_way;
   cache_pkg::way_t      victim_way;

   cache_way i_way0 (
      .clk        (clk),
      .reset      (reset),
      .index      (index),
      .word_sel   (word_sel),
      .word_write (way0_write),
      .wdata      (way_wdata),
      .line_fill  (way0_fill),
      .fill_tag   (fill_tag),
      .mark_dirty (way0_mark_dirty),
      .rdata      (way0_rdata),
      .tag_out    (way0_tag),
      .valid      (way0_valid),
      .dirty      (way0_dirty)
   );

   cache_way i_way1 (
      .clk        (clk),
      .reset      (reset),
      .index      (index),
      .word_sel   (word_sel),
      .word_write (way1_write),
      .wdata      (way_wdata),
      .line_fill  (way1_fill),
      .fill_tag   (fill_tag),
      .mark_dirty (way1_mark_dirty),
      .rdata      (way1_rdata),
      .tag_out    (way1_tag),
      .valid      (way1_valid),
      .dirty      (way1_dirty)
   );

   lru_table i_lru_table (
      .clk         (clk),
      .reset       (reset),
      .index       (index),
      .valid0      (way0_valid),
      .valid1      (way1_valid),
      .touch       (touch),
      .touched_way (touched_way),
      .victim_way  (victim_way)
   );

   cache_controller i_cache_controller (
      .clk             (clk),
      .reset           (reset),
      .req             (req),
      .wr              (wr),
      .addr            (addr),
      .data_in         (data_in),
      .done            (done),
      .cache_hit       (cache_hit),
      .data_out        (data_out),
      .mem_rd          (mem_rd),
      .mem_wr          (mem_wr),
      .mem_addr        (mem_addr),
      .mem_wdata       (mem_wdata),
      .mem_rdata       (mem_rdata),
      .index           (index),
      .word_sel        (word_sel),
      .way0_write      (way0_write),
      .way1_write      (way1_write),
      .way_wdata       (way_wdata),
      .way0_fill       (way0_fill),
      .way1_fill       (way1_fill),
      .fill_tag        (fill_tag),
      .way0_mark_dirty (way0_mark_dirty),
      .way1_mark_dirty (way1_mark_dirty),
      .way0_rdata      (way0_rdata),
      .way1_rdata      (way1_rdata),
      .way0_tag        (way0_tag),
      .way1_tag        (way1_tag),
      .way0_valid      (way0_valid),
      .way1_valid      (way1_valid),
      .way0_dirty      (way0_dirty),
      .way1_dirty      (way1_dirty),
      .touch           (touch),
      .touched_way     (touched_way),
      .victim_way      (victim_way)
   );

endmodule

`default_nettype wire

//--- bench/tb_main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_main_memory (
   input  logic             clk,
   input  logic             mem_rd,
   input  logic             mem_wr,
   input  cache_pkg::addr_t mem_addr,
   input  cache_pkg::word_t mem_wdata,
   output cache_pkg::word_t mem_rdata
);

   localparam int NUM_WORDS = 32768;

   cache_pkg::word_t words [NUM_WORDS];
   cache_pkg::word_t rd_pipe [cache_pkg::MEM_READ_LATENCY];

   // Odd multiplier keeps every word address distinct
   function automatic cache_pkg::word_t fill_word(input int unsigned word_addr);
      logic [31:0] prod;
      prod = word_addr * 32'd40503;
      return prod[15:0] ^ 16'hc35a;
   endfunction

   initial begin
      for (int i = 0; i < NUM_WORDS; i++) begin
         words[i] = fill_word(i);
      end
   end

   always @(posedge clk) begin
      if (mem_wr) begin
         words[mem_addr[15:1]] <= mem_wdata;
      end
      // X marks a cycle with no read in flight
      rd_pipe[0] <= mem_rd ? words[mem_addr[15:1]] : 'x;
      for (int i = 1; i < cache_pkg::MEM_READ_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign mem_rdata = rd_pipe[cache_pkg::MEM_READ_LATENCY-1];

endmodule

`default_nettype wire

//--- bench/tb_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_DELAY = 1;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_REQUESTS = 400;
   localparam int NUM_WORDS = 32768;
   localparam int HIT_CYCLES = 2;
   // Lookup, write-back, refill issue, read latency and finish plus slack
   localparam int MISS_CYCLES = 4 + 2 * cache_pkg::WORDS_PER_LINE
                                + cache_pkg::MEM_READ_LATENCY + 4;
   localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (MISS_CYCLES + 2) + RESET_CYCLES + 50;

   logic             clk;
   logic             reset;
   logic             req;
   logic             wr;
   cache_pkg::addr_t addr;
   cache_pkg::word_t data_in;
   logic             done;
   logic             cache_hit;
   cache_pkg::word_t data_out;
   logic             mem_rd;
   logic             mem_wr;
   cache_pkg::addr_t mem_addr;
   cache_pkg::word_t mem_wdata;
   cache_pkg::word_t mem_rdata;

   int error_count;
   int check_count;
   int hit_count;
   int miss_count;
   logic [31:0] lfsr_state;

   // Reference cache and memory
   cache_pkg::word_t model_mem [NUM_WORDS];
   logic             model_valid [2][cache_pkg::NUM_SETS];
   logic             model_dirty [2][cache_pkg::NUM_SETS];
   cache_pkg::tag_t  model_tag [2][cache_pkg::NUM_SETS];
   cache_pkg::word_t model_line [2][cache_pkg::NUM_SETS][cache_pkg::WORDS_PER_LINE];
   cache_pkg::way_t  model_lru [cache_pkg::NUM_SETS];

   // Memory strobes expected for the request in progress
   cache_pkg::addr_t exp_wr_addr [$];
   cache_pkg::word_t exp_wr_data [$];
   cache_pkg::addr_t exp_rd_addr [$];

   cache_top i_dut (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .done      (done),
      .cache_hit (cache_hit),
      .data_out  (data_out),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   tb_main_memory i_mem (
      .clk       (clk),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   initial begin
      clk = 1'b0;
   end

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Same pattern the memory model starts from
   function automatic cache_pkg::word_t initial_word(input int unsigned word_addr);
      logic [31:0] prod;
      prod = word_addr * 32'd40503;
      return prod[15:0] ^ 16'hc35a;
   endfunction

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] draw_bits(input int n);
      logic        fb;
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   function automatic cache_pkg::tag_t pick_tag(input logic [1:0] sel);
      case (sel)
         2'd0: return 5'h03;
         2'd1: return 5'h11;
         2'd2: return 5'h1c;
         default: return 5'h08;
      endcase
   endfunction

   function automatic cache_pkg::index_t pick_set(input logic [1:0] sel);
      case (sel)
         2'd0: return 8'h00;
         2'd1: return 8'h5a;
         2'd2: return 8'hff;
         default: return 8'h21;
      endcase
   endfunction

   task automatic check_word(input string name, input cache_pkg::word_t expected,
                             input cache_pkg::word_t actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("ERR %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("ERR %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic check_addr(input string name, input cache_pkg::addr_t expected,
                             input cache_pkg::addr_t actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("ERR %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic report_failure(input string what);
      error_count++;
      $display("%s", what);
   endtask

   task automatic init_model();
      for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
         for (int k = 0; k < 2; k++) begin
            model_valid[k][s] = 1'b0;
            model_dirty[k][s] = 1'b0;
            model_tag[k][s] = '0;
         end
         model_lru[s] = 1'b0;
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
         model_mem[i] = initial_word(i);
      end
   endtask

   // Updates the model and queues the memory traffic the access must cause
   task automatic predict_access(input logic is_store, input cache_pkg::addr_t a,
                                 input cache_pkg::word_t d, output logic hit,
                                 output cache_pkg::word_t rdata);
      cache_pkg::tag_t      t;
      cache_pkg::index_t    s;
      cache_pkg::word_sel_t w;
      cache_pkg::word_sel_t ws;
      cache_pkg::way_t      way;
      cache_pkg::way_t      v;
      cache_pkg::addr_t     line_addr;
      t = a[15:11];
      s = a[10:3];
      w = a[2:1];
      hit = 1'b0;
      way = 1'b0;
      rdata = '0;
      for (int k = 0; k < 2; k++) begin
         if (model_valid[k][s] && model_tag[k][s] == t) begin
            hit = 1'b1;
            way = k[0];
         end
      end
      if (hit && is_store) begin
         model_line[way][s][w] = d;
         model_dirty[way][s] = 1'b1;
      end else if (hit) begin
         rdata = model_line[way][s][w];
         model_lru[s] = ~way;
      end else if (is_store) begin
         // Write-around leaves the cache as it is
         exp_wr_addr.push_back(a);
         exp_wr_data.push_back(d);
         model_mem[a[15:1]] = d;
      end else begin
         if (!model_valid[0][s]) begin
            v = 1'b0;
         end else if (!model_valid[1][s]) begin
            v = 1'b1;
         end else begin
            v = model_lru[s];
         end
         if (model_valid[v][s] && model_dirty[v][s]) begin
            for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
               line_addr = {model_tag[v][s], s, i[1:0], 1'b0};
               exp_wr_addr.push_back(line_addr);
               exp_wr_data.push_back(model_line[v][s][i]);
               model_mem[line_addr[15:1]] = model_line[v][s][i];
            end
         end
         for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
            ws = w + i[1:0];
            exp_rd_addr.push_back({t, s, ws, 1'b0});
            model_line[v][s][i] = model_mem[{t, s, i[1:0]}];
         end
         model_tag[v][s] = t;
         model_valid[v][s] = 1'b1;
         model_dirty[v][s] = 1'b0;
         model_lru[s] = ~v;
         rdata = model_line[v][s][w];
      end
   endtask

   task automatic watch_memory(input string name);
      if (mem_rd && mem_wr) begin
         report_failure($sformatf("%s: mem_rd and mem_wr were high in the same cycle", name));
      end
      if (mem_wr) begin
         if (exp_wr_addr.size() == 0) begin
            report_failure($sformatf("%s: unexpected memory write to %h", name, mem_addr));
         end else begin
            check_addr({name, " write addr"}, exp_wr_addr.pop_front(), mem_addr);
            check_word({name, " write data"}, exp_wr_data.pop_front(), mem_wdata);
         end
      end
      if (mem_rd) begin
         if (exp_rd_addr.size() == 0) begin
            report_failure($sformatf("%s: unexpected memory read of %h", name, mem_addr));
         end else begin
            check_addr({name, " read addr"}, exp_rd_addr.pop_front(), mem_addr);
         end
      end
   endtask

   task automatic run_access(input int n, input logic is_store, input cache_pkg::addr_t a,
                             input cache_pkg::word_t d);
      logic             exp_hit;
      cache_pkg::word_t exp_data;
      int               cycles;
      string            name;
      name = $sformatf("req %0d %s %h", n, is_store ? "store" : "load", a);
      predict_access(is_store, a, d, exp_hit, exp_data);
      @(posedge clk);
      #(DRIVE_DELAY);
      req = 1'b1;
      wr = is_store;
      addr = a;
      data_in = d;
      @(negedge clk);
      if (done || mem_rd || mem_wr) begin
         report_failure($sformatf("%s: controller was not idle when the request came", name));
      end
      @(posedge clk);
      #(DRIVE_DELAY);
      req = 1'b0;
      wr = 1'b0;
      addr = '0;
      data_in = '0;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         watch_memory(name);
      end while (!done && cycles < MISS_CYCLES);
      if (!done) begin
         report_failure($sformatf("%s: no done within %0d cycles", name, MISS_CYCLES));
      end else begin
         check_flag({name, " hit"}, exp_hit, cache_hit);
         if (!is_store) begin
            check_word({name, " data"}, exp_data, data_out);
         end
         if (exp_hit) begin
            check_count++;
            if (cycles != HIT_CYCLES) begin
               error_count++;
               $display("ERR %s latency: expected %0d, actual %0d", name, HIT_CYCLES, cycles);
            end
         end
      end
      if (exp_wr_addr.size() != 0 || exp_rd_addr.size() != 0) begin
         report_failure($sformatf("%s: %0d memory writes and %0d reads never appeared",
                                  name, exp_wr_addr.size(), exp_rd_addr.size()));
         exp_wr_addr.delete();
         exp_wr_data.delete();
         exp_rd_addr.delete();
      end
      if (exp_hit) begin
         hit_count++;
      end else begin
         miss_count++;
      end
   endtask

   // Few tags and sets so that conflicts and evictions happen often
   task automatic random_access(input int n);
      logic [31:0]       bits;
      logic              is_store;
      cache_pkg::tag_t   t;
      cache_pkg::index_t s;
      logic [2:0]        offset;
      bits = draw_bits(3);
      is_store = (bits[2:0] < 3'd3);
      bits = draw_bits(2);
      t = pick_tag(bits[1:0]);
      bits = draw_bits(2);
      s = pick_set(bits[1:0]);
      bits = draw_bits(3);
      offset = bits[2:0];
      bits = draw_bits(16);
      run_access(n, is_store, {t, s, offset}, bits[15:0]);
   endtask

   task automatic check_idle_after_reset();
      repeat (3) begin
         @(negedge clk);
         if (done || mem_rd || mem_wr) begin
            report_failure("done or a memory strobe was high after reset with no request");
         end
      end
   endtask

   initial begin
      lfsr_state = 32'hc453;
      error_count = 0;
      check_count = 0;
      hit_count = 0;
      miss_count = 0;
      reset = 1'b1;
      req = 1'b0;
      wr = 1'b0;
      addr = '0;
      data_in = '0;
      init_model();
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      reset = 1'b0;
      check_idle_after_reset();
      for (int n = 0; n < NUM_REQUESTS; n++) begin
         random_access(n);
      end
      repeat (2) @(posedge clk);
      $display("%0d requests, %0d hits, %0d misses, %0d checks, %0d errors",
               NUM_REQUESTS, hit_count, miss_count, check_count, error_count);
      if (error_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before all requests completed",
               WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- cache_top.f
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/lru_table.sv
verilog/cache_controller.sv
verilog/cache_top.sv
bench/tb_main_memory.sv
bench/tb_cache_top.sv

//--- Bender.yml
package:
  name: cache_top

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_way.sv
  - verilog/lru_table.sv
  - verilog/cache_controller.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - bench/tb_main_memory.sv
      - bench/tb_cache_top.sv
